/* build.f */
src/core_pkg.sv
src/fetch_decode.sv
src/pipeline_control.sv
src/rename_table.sv
src/reservation_station.sv
src/alu_unit.sv
src/mul_unit.sv
src/reorder_buffer.sv
src/core_top.sv
sim/tb_core_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_core_top &&
    { out=$(./obj_dir/Vtb_core_top); printf '%s\n' "$out";
      printf '%s\n' "$out" | grep -qF '*** PASSED ***'; } ||
    { echo "Simulation did not pass"; exit 1; }
echo "Simulation finished cleanly"
exit 0

/* sim/tb_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
    import core_pkg::*;

    localparam int NUM_RANDOM   = 20;
    localparam int RANDOM_LEN   = 40;
    localparam int DRAIN_CYCLES = 8;

    logic    clk = 1'b0;
    logic    rst_sync = 1'b1;
    pc_t     imem_addr;
    instr_t  imem_data;
    commit_t commit;
    logic    done;

    instr_t      prog [256];
    int          prog_len;
    areg_t       exp_rd [256];
    data_t       exp_val [256];
    int          exp_count;
    int          commit_idx;
    int          done_cycles;
    int          cycle;
    int          run_start;
    int          run_limit = 1000;
    logic [31:0] lfsr = 32'h90be;

    core_top #(
        .ROB_DEPTH  (ROB_DEPTH),
        .RS_DEPTH   (RS_DEPTH),
        .MUL_STAGES (MUL_STAGES)
    ) i_core_top (
        .clk, .rst_sync, .imem_addr, .imem_data, .commit, .done
    );

    always #5 clk = ~clk;

    // Instruction memory answers in the same cycle
    assign imem_data = prog[imem_addr];

    // ==============================
    // Stimulus helpers
    // ==============================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic instr_t ldi_word(areg_t rd, data_t imm);
        return {OP_LDI, rd, imm};
    endfunction

    function automatic instr_t rr_word(opcode_t op, areg_t rd, areg_t rs1, areg_t rs2);
        return {op, rd, rs1, rs2};
    endfunction

    function automatic instr_t halt_word();
        return {OP_HALT, 12'h000};
    endfunction

    // Unused slots hold a HALT tagged with its own address
    task automatic clear_program();
        for (int a = 0; a < 256; a++) begin
            prog[a] = {OP_HALT, 4'h0, 8'(a)};
        end
        prog_len = 0;
    endtask

    task automatic emit(instr_t w);
        prog[prog_len] = w;
        prog_len       = prog_len + 1;
    endtask

    // ==============================
    // Reference model
    // ==============================

    function automatic data_t ref_result(opcode_t op, data_t a, data_t b, data_t imm);
        logic [15:0] prod;
        prod = 16'(a) * 16'(b);
        case (op)
            OP_LDI:  return imm;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return prod[7:0];
            OP_MULH: return prod[15:8];
            default: return '0;
        endcase
    endfunction

    // Sequential run from all-zero registers, one entry per retiring op
    task automatic build_expected();
        data_t   regs [16];
        instr_t  ins;
        opcode_t op;
        logic    halted;
        for (int r = 0; r < 16; r++) begin
            regs[r] = '0;
        end
        exp_count = 0;
        halted    = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            ins = prog[i];
            op  = opcode_t'(ins[15:12]);
            if (op == OP_HALT) begin
                halted = 1'b1;
            end
            if (!halted && op inside {OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR,
                                      OP_MUL, OP_MULH}) begin
                regs[ins[11:8]] = ref_result(op, regs[ins[7:4]], regs[ins[3:0]],
                                             ins[7:0]);
                exp_rd[exp_count]  = ins[11:8];
                exp_val[exp_count] = regs[ins[11:8]];
                exp_count          = exp_count + 1;
            end
        end
    endtask

    // ==============================
    // Checking
    // ==============================

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_commit(commit_t got);
        rob_tag_t tag_exp;
        string    msg;
        tag_exp = rob_tag_t'(commit_idx % ROB_DEPTH);
        if (commit_idx >= exp_count) begin
            report_fail($sformatf("Unexpected commit at %0t: r%0d=%02h after all %0d entries",
                                  $time, got.rd, got.value, exp_count));
        end else if (got.rd !== exp_rd[commit_idx] || got.value !== exp_val[commit_idx]
                     || got.tag !== tag_exp) begin
            msg = $sformatf("Mismatch at %0t: commit %0d expected r%0d=%02h tag %0d",
                            $time, commit_idx, exp_rd[commit_idx], exp_val[commit_idx],
                            tag_exp);
            report_fail({msg, $sformatf(", got r%0d=%02h tag %0d",
                                        got.rd, got.value, got.tag)});
        end
    endtask

    task automatic check_done(logic level, int seen);
        if (!level) begin
            report_fail($sformatf("The done level fell again at %0t", $time));
        end else if (seen != exp_count) begin
            report_fail($sformatf("Done was high at %0t after %0d commits, but %0d were expected",
                                  $time, seen, exp_count));
        end
    endtask

    // Outputs are sampled half a cycle after the edge
    always @(negedge clk) begin
        if (rst_sync) begin
            commit_idx  = 0;
            done_cycles = 0;
        end else begin
            if (commit.valid) begin
                check_commit(commit);
                commit_idx = commit_idx + 1;
            end
            if (done || done_cycles != 0) begin
                check_done(done, commit_idx);
                done_cycles = done_cycles + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle - run_start > run_limit) begin
            report_fail($sformatf("Timeout: program did not drain within %0d cycles",
                                  run_limit));
        end
    end

    // ==============================
    // Programs
    // ==============================

    task automatic ldi_sequence();
        clear_program();
        for (int r = 0; r < 16; r++) begin
            emit(ldi_word(areg_t'(r), data_t'((r * 29) ^ 8'ha5)));
        end
        emit(halt_word());
    endtask

    // Every op reads the result just produced
    task automatic alu_dependency_chain();
        clear_program();
        emit(ldi_word(4'd1, 8'h5a));
        emit(ldi_word(4'd2, 8'h33));
        emit(rr_word(OP_ADD, 4'd3, 4'd1, 4'd2));
        emit(rr_word(OP_SUB, 4'd4, 4'd3, 4'd2));
        emit(rr_word(OP_XOR, 4'd5, 4'd4, 4'd3));
        emit(rr_word(OP_AND, 4'd6, 4'd5, 4'd1));
        emit(rr_word(OP_ADD, 4'd7, 4'd6, 4'd6));
        emit(rr_word(OP_SUB, 4'd8, 4'd7, 4'd5));
        emit(rr_word(OP_ADD, 4'd8, 4'd8, 4'd3));
        emit(rr_word(OP_XOR, 4'd9, 4'd8, 4'd7));
        emit(halt_word());
    endtask

    task automatic mul_then_alu();
        clear_program();
        emit(ldi_word(4'd1, 8'hc7));
        emit(ldi_word(4'd2, 8'h5d));
        emit(rr_word(OP_MUL, 4'd3, 4'd1, 4'd2));
        emit(rr_word(OP_MULH, 4'd4, 4'd1, 4'd2));
        emit(ldi_word(4'd5, 8'h21));
        emit(rr_word(OP_ADD, 4'd6, 4'd5, 4'd5));
        emit(ldi_word(4'd7, 8'h0f));
        emit(rr_word(OP_XOR, 4'd8, 4'd7, 4'd6));
        emit(rr_word(OP_ADD, 4'd9, 4'd3, 4'd4));
        emit(halt_word());
    endtask

    // Slow multiply chain at the head with quick multiplies behind it
    // Fills the mul station and then the ROB
    task automatic mul_pressure_run();
        clear_program();
        emit(ldi_word(4'd1, 8'h07));
        emit(ldi_word(4'd2, 8'h0b));
        emit(ldi_word(4'd3, 8'hd3));
        for (int k = 0; k < 4; k++) begin
            emit(rr_word(OP_MUL, 4'd1, 4'd1, 4'd2));
        end
        for (int k = 0; k < 8; k++) begin
            if (k % 2 == 0) begin
                emit(rr_word(OP_MUL, areg_t'(4 + k), 4'd2, 4'd3));
            end else begin
                emit(rr_word(OP_MULH, areg_t'(4 + k), 4'd3, 4'd3));
            end
        end
        emit(halt_word());
    endtask

    task automatic random_program();
        int    sel;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        clear_program();
        for (int i = 0; i < RANDOM_LEN - 1; i++) begin
            // Every fifth slot forces one op so all seven appear
            if (i % 5 == 4) begin
                sel = i / 5;
            end else begin
                sel = int'(rand_bits(3));
            end
            rd  = areg_t'(rand_bits(3));
            rs1 = areg_t'(rand_bits(3));
            rs2 = areg_t'(rand_bits(3));
            case (sel)
                1:       emit(rr_word(OP_ADD, rd, rs1, rs2));
                2:       emit(rr_word(OP_SUB, rd, rs1, rs2));
                3:       emit(rr_word(OP_AND, rd, rs1, rs2));
                4:       emit(rr_word(OP_XOR, rd, rs1, rs2));
                5:       emit(rr_word(OP_MUL, rd, rs1, rs2));
                6:       emit(rr_word(OP_MULH, rd, rs1, rs2));
                default: emit(ldi_word(rd, data_t'(rand_bits(8))));
            endcase
        end
        emit(halt_word());
    endtask

    // Fresh reset, then wait until done has held for a while
    task automatic run_program(string name);
        build_expected();
        @(posedge clk);
        #1;
        rst_sync  = 1'b1;
        run_start = cycle;
        run_limit = 30 * prog_len + 100;
        repeat (4) @(posedge clk);
        #1;
        rst_sync = 1'b0;
        wait (done_cycles == DRAIN_CYCLES);
        $display("%s: %0d commits in program order", name, exp_count);
    endtask

    initial begin
        cycle     = 0;
        run_start = 0;
        clear_program();

        ldi_sequence();
        run_program("ldi sequence");
        alu_dependency_chain();
        run_program("alu chain");
        mul_then_alu();
        run_program("mul then alu");
        mul_pressure_run();
        run_program("mul pressure");
        for (int p = 0; p < NUM_RANDOM; p++) begin
            random_program();
            run_program($sformatf("random %0d", p));
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* src/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter int ROB_DEPTH  = core_pkg::ROB_DEPTH,
    parameter int RS_DEPTH   = core_pkg::RS_DEPTH,
    parameter int MUL_STAGES = core_pkg::MUL_STAGES
) (
    input  wire                   clk,
    input  wire                   rst_sync,
    output core_pkg::pc_t         imem_addr,
    input  wire core_pkg::instr_t imem_data,
    output core_pkg::commit_t     commit,
    output logic                  done
);
    import core_pkg::*;

    decoded_op_t dop;
    logic        stall;
    logic        dispatch_alu;
    logic        dispatch_mul;
    logic        dispatch_rob;
    logic        alu_full;
    logic        mul_full;
    logic        rob_full;
    logic        rob_empty;
    rob_tag_t    alloc_tag;
    rob_tag_t    query1;
    rob_tag_t    query2;
    rob_read_t   rob_ans1;
    rob_read_t   rob_ans2;
    operand_t    src1;
    operand_t    src2;
    cdb_t        cdb_alu;
    cdb_t        cdb_mul;

    // Station to unit issue buses
    logic        alu_issue_valid;
    logic        mul_issue_valid;
    rob_tag_t    alu_issue_tag;
    rob_tag_t    mul_issue_tag;
    data_t       alu_a;
    data_t       alu_b;
    data_t       mul_a;
    data_t       mul_b;
    alu_func_t   alu_func;
    mul_func_t   mul_func;

    fetch_decode i_fetch_decode (
        .clk, .rst_sync,
        .stall, .imem_addr, .imem_data, .dop
    );

    pipeline_control i_pipeline_control (
        .clk, .rst_sync, .dop,
        .alu_full, .mul_full, .rob_full, .rob_empty,
        .stall, .dispatch_alu, .dispatch_mul, .dispatch_rob, .done
    );

    rename_table i_rename_table (
        .clk, .rst_sync, .dop,
        .dispatch (dispatch_rob),
        .alloc_tag, .query1, .query2, .rob_ans1, .rob_ans2,
        .cdb_alu, .cdb_mul, .commit, .src1, .src2
    );

    reorder_buffer #(.DEPTH(ROB_DEPTH)) i_reorder_buffer (
        .clk, .rst_sync,
        .dispatch    (dispatch_rob),
        .dispatch_rd (dop.rd),
        .alloc_tag, .query1, .query2, .rob_ans1, .rob_ans2,
        .cdb_alu, .cdb_mul,
        .full  (rob_full),
        .empty (rob_empty),
        .commit
    );

    // ==============================
    // Execution lanes
    // ==============================

    reservation_station #(.DEPTH(RS_DEPTH), .payload_t(alu_func_t)) alu_station (
        .clk, .rst_sync,
        .insert      (dispatch_alu),
        .ins_tag     (alloc_tag),
        .ins_func    (dop.alu_func),
        .src1, .src2, .cdb_alu, .cdb_mul,
        .full        (alu_full),
        .issue_valid (alu_issue_valid),
        .issue_tag   (alu_issue_tag),
        .issue_a     (alu_a),
        .issue_b     (alu_b),
        .issue_func  (alu_func)
    );

    reservation_station #(.DEPTH(RS_DEPTH), .payload_t(mul_func_t)) mul_station (
        .clk, .rst_sync,
        .insert      (dispatch_mul),
        .ins_tag     (alloc_tag),
        .ins_func    (dop.mul_func),
        .src1, .src2, .cdb_alu, .cdb_mul,
        .full        (mul_full),
        .issue_valid (mul_issue_valid),
        .issue_tag   (mul_issue_tag),
        .issue_a     (mul_a),
        .issue_b     (mul_b),
        .issue_func  (mul_func)
    );

    alu_unit i_alu_unit (
        .clk, .rst_sync,
        .issue_valid (alu_issue_valid),
        .issue_tag   (alu_issue_tag),
        .issue_a     (alu_a),
        .issue_b     (alu_b),
        .issue_func  (alu_func),
        .result      (cdb_alu)
    );

    mul_unit #(.STAGES(MUL_STAGES)) i_mul_unit (
        .clk, .rst_sync,
        .issue_valid (mul_issue_valid),
        .issue_tag   (mul_issue_tag),
        .issue_a     (mul_a),
        .issue_b     (mul_b),
        .issue_func  (mul_func),
        .result      (cdb_mul)
    );

endmodule

`default_nettype wire

/* src/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int DEPTH = 8
) (
    input  wire                      clk,
    input  wire                      rst_sync,
    input  wire                      dispatch,
    input  wire core_pkg::areg_t     dispatch_rd,
    output core_pkg::rob_tag_t       alloc_tag,
    input  wire core_pkg::rob_tag_t  query1,
    input  wire core_pkg::rob_tag_t  query2,
    output core_pkg::rob_read_t      rob_ans1,
    output core_pkg::rob_read_t      rob_ans2,
    input  wire core_pkg::cdb_t      cdb_alu,
    input  wire core_pkg::cdb_t      cdb_mul,
    output logic                     full,
    output logic                     empty,
    output core_pkg::commit_t        commit
);
    import core_pkg::*;

    localparam int CW = $clog2(DEPTH + 1);

    areg_t            ent_rd [DEPTH];
    data_t            ent_value [DEPTH];
    logic [DEPTH-1:0] ent_done;
    rob_tag_t         head;
    rob_tag_t         tail;
    logic [CW-1:0]    count;
    logic             retire;

    function automatic rob_tag_t bump(rob_tag_t p);
        return (p == rob_tag_t'(DEPTH - 1)) ? rob_tag_t'(0) : p + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign full      = (count == CW'(DEPTH));
    assign empty     = (count == '0);
    assign retire    = !empty && ent_done[head];
    assign rob_ans1  = '{done: ent_done[query1], value: ent_value[query1]};
    assign rob_ans2  = '{done: ent_done[query2], value: ent_value[query2]};

    // ==============================
    // Pointers and completion
    // ==============================

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
        end else begin
            if (cdb_alu.valid) begin
                ent_done[cdb_alu.tag] <= 1'b1;
            end
            if (cdb_mul.valid) begin
                ent_done[cdb_mul.tag] <= 1'b1;
            end
            if (dispatch) begin
                ent_done[tail] <= 1'b0;
                tail           <= bump(tail);
            end
            if (retire) begin
                head <= bump(head);
            end
            count <= count + CW'(dispatch) - CW'(retire);
        end
    end

    // ==============================
    // Entry data and retirement
    // ==============================

    always_ff @(posedge clk) begin
        if (dispatch) begin
            ent_rd[tail] <= dispatch_rd;
        end
        if (cdb_alu.valid) begin
            ent_value[cdb_alu.tag] <= cdb_alu.value;
        end
        if (cdb_mul.valid) begin
            ent_value[cdb_mul.tag] <= cdb_mul.value;
        end
        commit.rd    <= ent_rd[head];
        commit.value <= ent_value[head];
        commit.tag   <= head;
        if (rst_sync) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= retire;
        end
    end

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int STAGES = 3
) (
    input  wire                       clk,
    input  wire                       rst_sync,
    input  wire                       issue_valid,
    input  wire core_pkg::rob_tag_t   issue_tag,
    input  wire core_pkg::data_t      issue_a,
    input  wire core_pkg::data_t      issue_b,
    input  wire core_pkg::mul_func_t  issue_func,
    output core_pkg::cdb_t            result
);
    import core_pkg::*;

    localparam int LAST = STAGES - 2;

    // STAGES-1 internal stages, the result register is the final one
    logic [LAST:0] vld;
    rob_tag_t      tag [LAST+1];
    mul_func_t     func [LAST+1];
    logic [15:0]   prod [LAST+1];

    always_ff @(posedge clk) begin
        tag[0]  <= issue_tag;
        func[0] <= issue_func;
        prod[0] <= 16'(issue_a) * 16'(issue_b);
        for (int i = 1; i <= LAST; i++) begin
            tag[i]  <= tag[i-1];
            func[i] <= func[i-1];
            prod[i] <= prod[i-1];
        end
        // Byte select
        result.tag   <= tag[LAST];
        result.value <= (func[LAST] == MUL_HI) ? prod[LAST][15:8] : prod[LAST][7:0];
        if (rst_sync) begin
            vld          <= '0;
            result.valid <= 1'b0;
        end else begin
            vld[0] <= issue_valid;
            for (int i = 1; i <= LAST; i++) begin
                vld[i] <= vld[i-1];
            end
            result.valid <= vld[LAST];
        end
    end

endmodule

`default_nettype wire

/* src/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                       clk,
    input  wire                       rst_sync,
    input  wire                       issue_valid,
    input  wire core_pkg::rob_tag_t   issue_tag,
    input  wire core_pkg::data_t      issue_a,
    input  wire core_pkg::data_t      issue_b,
    input  wire core_pkg::alu_func_t  issue_func,
    output core_pkg::cdb_t            result
);
    import core_pkg::*;

    data_t value;

    always_comb begin
        case (issue_func)
            ALU_ADD: value = issue_a + issue_b;
            ALU_SUB: value = issue_a - issue_b;
            ALU_AND: value = issue_a & issue_b;
            ALU_XOR: value = issue_a ^ issue_b;
            default: value = issue_a;  // LDI carries the immediate in a
        endcase
    end

    always_ff @(posedge clk) begin
        result.tag   <= issue_tag;
        result.value <= value;
        if (rst_sync) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue_valid;
        end
    end

endmodule

`default_nettype wire

/* src/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  wire                     clk,
    input  wire                     rst_sync,
    input  wire                     insert,
    input  wire core_pkg::rob_tag_t ins_tag,
    input  wire payload_t           ins_func,
    input  wire core_pkg::operand_t src1,
    input  wire core_pkg::operand_t src2,
    input  wire core_pkg::cdb_t     cdb_alu,
    input  wire core_pkg::cdb_t     cdb_mul,
    output logic                    full,
    output logic                    issue_valid,
    output core_pkg::rob_tag_t      issue_tag,
    output core_pkg::data_t         issue_a,
    output core_pkg::data_t         issue_b,
    output payload_t                issue_func
);
    import core_pkg::*;

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0] valid;
    rob_tag_t         ent_tag [DEPTH];
    payload_t         ent_func [DEPTH];
    operand_t         ent_a [DEPTH];
    operand_t         ent_b [DEPTH];
    logic [IW-1:0]    free_idx;
    logic [IW-1:0]    issue_idx;

    // Wake-up from either result lane
    function automatic operand_t wake(operand_t op);
        operand_t res;
        res = op;
        if (!op.ready && cdb_alu.valid && cdb_alu.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = cdb_alu.value;
        end else if (!op.ready && cdb_mul.valid && cdb_mul.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = cdb_mul.value;
        end
        return res;
    endfunction

    // ==============================
    // Slot selection
    // ==============================

    // Downward scan leaves the lowest index selected
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IW'(i);
            end
            if (valid[i] && ent_a[i].ready && ent_b[i].ready) begin
                issue_valid = 1'b1;
                issue_idx   = IW'(i);
            end
        end
    end

    assign full       = &valid;
    assign issue_tag  = ent_tag[issue_idx];
    assign issue_a    = ent_a[issue_idx].value;
    assign issue_b    = ent_b[issue_idx].value;
    assign issue_func = ent_func[issue_idx];

    // ==============================
    // Entry state
    // ==============================

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[issue_idx] <= 1'b0;
            end
            if (insert && !full) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_a[i] <= wake(ent_a[i]);
            ent_b[i] <= wake(ent_b[i]);
        end
        if (insert && !full) begin
            ent_tag[free_idx]  <= ins_tag;
            ent_func[free_idx] <= ins_func;
            ent_a[free_idx]    <= src1;
            ent_b[free_idx]    <= src2;
        end
    end

endmodule

`default_nettype wire

/* src/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_table (
    input  wire                        clk,
    input  wire                        rst_sync,
    input  wire core_pkg::decoded_op_t dop,
    input  wire                        dispatch,
    input  wire core_pkg::rob_tag_t    alloc_tag,
    output core_pkg::rob_tag_t         query1,
    output core_pkg::rob_tag_t         query2,
    input  wire core_pkg::rob_read_t   rob_ans1,
    input  wire core_pkg::rob_read_t   rob_ans2,
    input  wire core_pkg::cdb_t        cdb_alu,
    input  wire core_pkg::cdb_t        cdb_mul,
    input  wire core_pkg::commit_t     commit,
    output core_pkg::operand_t         src1,
    output core_pkg::operand_t         src2
);
    import core_pkg::*;

    data_t       regs [16];
    rob_tag_t    alias_tag [16];
    logic [15:0] busy;
    logic        is_ldi;

    // Register file, then ROB, then result lanes
    function automatic operand_t resolve(data_t val, logic is_busy, rob_tag_t tag,
                                         rob_read_t ans);
        operand_t op;
        op.ready = 1'b1;
        op.tag   = tag;
        op.value = val;
        if (is_busy) begin
            if (ans.done) begin
                op.value = ans.value;
            end else if (cdb_alu.valid && cdb_alu.tag == tag) begin
                op.value = cdb_alu.value;
            end else if (cdb_mul.valid && cdb_mul.tag == tag) begin
                op.value = cdb_mul.value;
            end else begin
                op.ready = 1'b0;
            end
        end
        return op;
    endfunction

    assign query1 = alias_tag[dop.rs1];
    assign query2 = alias_tag[dop.rs2];
    assign is_ldi = (dop.unit == UNIT_ALU) && (dop.alu_func == ALU_LDI);

    always_comb begin
        src1 = resolve(regs[dop.rs1], busy[dop.rs1], query1, rob_ans1);
        src2 = resolve(regs[dop.rs2], busy[dop.rs2], query2, rob_ans2);
        // LDI has no register sources
        if (is_ldi) begin
            src1 = '{ready: 1'b1, tag: '0, value: dop.imm};
            src2 = '{ready: 1'b1, tag: '0, value: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            for (int i = 0; i < 16; i++) begin
                regs[i]      <= '0;
                alias_tag[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (commit.valid) begin
                regs[commit.rd] <= commit.value;
                if (alias_tag[commit.rd] == commit.tag) begin
                    busy[commit.rd] <= 1'b0;
                end
            end
            // A new rename of the same rd wins
            if (dispatch) begin
                busy[dop.rd]      <= 1'b1;
                alias_tag[dop.rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  wire                        clk,
    input  wire                        rst_sync,
    input  wire core_pkg::decoded_op_t dop,
    input  wire                        alu_full,
    input  wire                        mul_full,
    input  wire                        rob_full,
    input  wire                        rob_empty,
    output logic                       stall,
    output logic                       dispatch_alu,
    output logic                       dispatch_mul,
    output logic                       dispatch_rob,
    output logic                       done
);
    import core_pkg::*;

    logic halted;
    logic target_full;
    logic accept;

    // HALT never waits on a full structure
    assign target_full  = (dop.unit == UNIT_MUL) ? mul_full : alu_full;
    assign stall        = halted | (dop.valid & !dop.is_halt & (rob_full | target_full));
    assign accept       = dop.valid & !stall;
    assign dispatch_rob = accept & !dop.is_halt;
    assign dispatch_alu = dispatch_rob & (dop.unit == UNIT_ALU);
    assign dispatch_mul = dispatch_rob & (dop.unit == UNIT_MUL);

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            halted <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (accept && dop.is_halt) begin
                halted <= 1'b1;
            end
            // Program drained
            if (halted && rob_empty) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/fetch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
    input  wire                   clk,
    input  wire                   rst_sync,
    input  wire                   stall,
    output core_pkg::pc_t         imem_addr,
    input  wire core_pkg::instr_t imem_data,
    output core_pkg::decoded_op_t dop
);
    import core_pkg::*;

    pc_t         pc;
    logic        stopped;
    decoded_op_t next_op;

    assign imem_addr = pc;

    always_comb begin
        next_op       = '0;
        next_op.valid = 1'b1;
        next_op.rd    = imem_data[11:8];
        next_op.rs1   = imem_data[7:4];
        next_op.rs2   = imem_data[3:0];
        next_op.imm   = imem_data[7:0];
        case (opcode_t'(imem_data[15:12]))
            OP_LDI:  next_op.alu_func = ALU_LDI;
            OP_ADD:  next_op.alu_func = ALU_ADD;
            OP_SUB:  next_op.alu_func = ALU_SUB;
            OP_AND:  next_op.alu_func = ALU_AND;
            OP_XOR:  next_op.alu_func = ALU_XOR;
            OP_MUL: begin
                next_op.unit     = UNIT_MUL;
                next_op.mul_func = MUL_LO;
            end
            OP_MULH: begin
                next_op.unit     = UNIT_MUL;
                next_op.mul_func = MUL_HI;
            end
            OP_HALT: next_op.is_halt = 1'b1;
            default: next_op.valid = 1'b0;
        endcase
    end

    // Op and PC hold while stalled; nothing new is fetched after HALT
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            pc      <= '0;
            stopped <= 1'b0;
            dop     <= '0;
        end else if (!stall) begin
            if (stopped) begin
                dop.valid <= 1'b0;
            end else begin
                dop     <= next_op;
                pc      <= pc + 1'b1;
                stopped <= next_op.valid & next_op.is_halt;
            end
        end
    end

endmodule

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Default sizes, passed down from core_top
    parameter int ROB_DEPTH  = 8;
    parameter int RS_DEPTH   = 4;
    parameter int MUL_STAGES = 3;

    typedef logic [7:0]                   data_t;
    typedef logic [15:0]                  instr_t;
    typedef logic [3:0]                   areg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [7:0]                   pc_t;

    // Held in instr[15:12], unlisted values decode as a no-op
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_XOR  = 4'h5,
        OP_MUL  = 4'h6,
        OP_MULH = 4'h7,
        OP_HALT = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_LDI,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } alu_func_t;

    typedef enum logic {
        MUL_LO,
        MUL_HI
    } mul_func_t;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_t;

    // Layout: rd [11:8], rs1 [7:4], rs2 [3:0], LDI immediate [7:0]
    typedef struct packed {
        logic      valid;
        unit_t     unit;
        alu_func_t alu_func;
        mul_func_t mul_func;
        areg_t     rd;
        areg_t     rs1;
        areg_t     rs2;
        data_t     imm;
        logic      is_halt;
    } decoded_op_t;

    // Source operand, either captured or waiting on tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        data_t    value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        logic  done;
        data_t value;
    } rob_read_t;

    typedef struct packed {
        logic     valid;
        areg_t    rd;
        data_t    value;
        rob_tag_t tag;
    } commit_t;

endpackage

`default_nettype wire
